// ==== logic/l2_cache_consts.svh ====
`ifndef L2_CACHE_CONSTS_SVH
`define L2_CACHE_CONSTS_SVH

// Associativity and number of sets
`define L2_NUM_WAYS 4
`define L2_NUM_SETS 16

// Line address split: low bits select the set, the rest is the tag
`define L2_SET_WIDTH 4
`define L2_TAG_WIDTH 8
`define L2_ADDR_WIDTH 12

// One line is eight bytes, one mask bit per byte
`define L2_LINE_WIDTH 64
`define L2_MASK_WIDTH 8

// Hardware threads that can hold a sync link
`define L2_NUM_STRANDS 4

// Data memory index, way in the upper bits and set in the lower
`define L2_INDEX_WIDTH 6

`endif

// ==== logic/l2_cache_pkg.sv ====
`default_nettype none

`include "l2_cache_consts.svh"

package l2_cache_pkg;

	// Request opcodes
	typedef enum logic [2:0]
	{
		OP_LOAD = 3'd0,
		OP_STORE = 3'd1,
		OP_FLUSH = 3'd2,
		OP_LOAD_SYNC = 3'd3,
		OP_STORE_SYNC = 3'd4,
		OP_FILL = 3'd5
	} l2_op_t;

	// One request as it moves down the pipeline
	typedef struct packed
	{
		l2_op_t op;
		logic [$clog2(`L2_NUM_STRANDS)-1:0] strand;
		logic [`L2_ADDR_WIDTH-1:0] address;
		logic [`L2_LINE_WIDTH-1:0] data;
		logic [`L2_MASK_WIDTH-1:0] mask;
	} l2_request_t;

endpackage

`default_nettype wire

// ==== logic/l2_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_consts.svh"

interface l2_stage_if
	import l2_cache_pkg::*;
();
	logic valid;
	l2_request_t req;
	logic hit;
	// Hit way, or the replacement way when the lookup missed
	logic [`L2_INDEX_WIDTH-`L2_SET_WIDTH-1:0] way;
	// Dirty bit of the line under way
	logic line_dirty;
	// Tag stored in that way, used for the writeback address
	logic [`L2_TAG_WIDTH-1:0] victim_tag;

	modport source
	(
		output valid,
		output req,
		output hit,
		output way,
		output line_dirty,
		output victim_tag
	);

	modport sink
	(
		input valid,
		input req,
		input hit,
		input way,
		input line_dirty,
		input victim_tag
	);
endinterface

`default_nettype wire

// ==== logic/l2_cache_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_cache_sram
#(
	parameter DATA_WIDTH = 64,
	parameter ADDR_WIDTH = 6
)
(
	input wire clk,
	input wire [ADDR_WIDTH-1:0] rd_index,
	output logic [DATA_WIDTH-1:0] rd_data,
	input wire wr_enable,
	input wire [ADDR_WIDTH-1:0] wr_index,
	input wire [DATA_WIDTH-1:0] wr_data
);
	logic [DATA_WIDTH-1:0] mem [2 ** ADDR_WIDTH];

	// Read before write, a colliding read returns the old line
	always_ff @(posedge clk)
	begin
		if (wr_enable)
			mem[wr_index] <= wr_data;
		rd_data <= mem[rd_index];
	end
endmodule

`default_nettype wire

// ==== logic/l2_cache_tag.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_consts.svh"

module l2_cache_tag
	import l2_cache_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire req_valid,
	input wire l2_request_t req,
	l2_stage_if.source out
);
	localparam WAY_WIDTH = `L2_INDEX_WIDTH - `L2_SET_WIDTH;

	logic [`L2_TAG_WIDTH-1:0] tag_mem [`L2_NUM_SETS][`L2_NUM_WAYS];
	logic [`L2_NUM_WAYS-1:0] valid [`L2_NUM_SETS];
	logic [`L2_NUM_WAYS-1:0] dirty [`L2_NUM_SETS];
	logic [WAY_WIDTH-1:0] rr_ptr [`L2_NUM_SETS];

	logic [`L2_SET_WIDTH-1:0] req_set;
	logic [`L2_TAG_WIDTH-1:0] req_tag;
	logic [`L2_NUM_WAYS-1:0] way_hit;
	logic hit;
	logic [WAY_WIDTH-1:0] hit_way;
	logic [WAY_WIDTH-1:0] victim_way;
	logic [WAY_WIDTH-1:0] report_way;

	assign req_set = req.address[`L2_SET_WIDTH-1:0];
	assign req_tag = req.address[`L2_ADDR_WIDTH-1:`L2_SET_WIDTH];

	// Walk the ways from the top so the lowest match or free way wins
	always_comb
	begin
		hit_way = '0;
		victim_way = rr_ptr[req_set];
		for (int w = `L2_NUM_WAYS - 1; w >= 0; w--)
		begin
			way_hit[w] = valid[req_set][w] && tag_mem[req_set][w] == req_tag;
			if (way_hit[w])
				hit_way = WAY_WIDTH'(w);
			if (!valid[req_set][w])
				victim_way = WAY_WIDTH'(w);
		end
	end

	assign hit = |way_hit;
	assign report_way = hit ? hit_way : victim_way;

	// Directory update
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int s = 0; s < `L2_NUM_SETS; s++)
			begin
				valid[s] <= '0;
				dirty[s] <= '0;
				rr_ptr[s] <= '0;
			end
		end
		else if (req_valid)
		begin
			case (req.op)
				OP_FILL:
				begin
					tag_mem[req_set][report_way] <= req_tag;
					valid[req_set][report_way] <= 1'b1;
					dirty[req_set][report_way] <= 1'b0;
					if (!hit)
						rr_ptr[req_set] <= rr_ptr[req_set] + 1'b1;
				end

				// A sync store marks the line even if it fails later
				OP_STORE, OP_STORE_SYNC:
				begin
					if (hit)
						dirty[req_set][hit_way] <= 1'b1;
				end

				OP_FLUSH:
				begin
					if (hit)
						dirty[req_set][hit_way] <= 1'b0;
				end

				default:
				begin
				end
			endcase
		end
	end

	// Lookup results, state as it was before this request
	always_ff @(posedge clk)
	begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= req_valid;
		out.req <= req;
		out.hit <= hit;
		out.way <= report_way;
		out.line_dirty <= dirty[req_set][report_way];
		out.victim_tag <= tag_mem[req_set][report_way];
	end
endmodule

`default_nettype wire

// ==== logic/l2_cache_read.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_consts.svh"

module l2_cache_read
	import l2_cache_pkg::*;
(
	input wire clk,
	input wire reset,
	l2_stage_if.sink in,
	l2_stage_if.source out,
	output logic [`L2_LINE_WIDTH-1:0] line_data,
	output logic sync_success,
	input wire wr_enable,
	input wire [`L2_INDEX_WIDTH-1:0] wr_index,
	input wire [`L2_LINE_WIDTH-1:0] wr_data,
	output logic [`L2_INDEX_WIDTH-1:0] rd_index,
	input wire [`L2_LINE_WIDTH-1:0] rd_data
);
	logic [`L2_ADDR_WIDTH-1:0] link_addr [`L2_NUM_STRANDS];
	logic [`L2_NUM_STRANDS-1:0] link_valid;
	logic link_match;
	logic bypass_valid;
	logic [`L2_LINE_WIDTH-1:0] bypass_data;

	// Hit way on a hit, victim way on a fill miss
	assign rd_index = {in.way, in.req.address[`L2_SET_WIDTH-1:0]};

	assign link_match = link_valid[in.req.strand]
		&& link_addr[in.req.strand] == in.req.address;

	// The memory returns the old line when written at the read edge
	assign line_data = bypass_valid ? bypass_data : rd_data;

	always_ff @(posedge clk)
	begin
		if (reset)
			bypass_valid <= 1'b0;
		else
			bypass_valid <= wr_enable && wr_index == rd_index;
		bypass_data <= wr_data;
	end

	// Sync links, one per strand
	always_ff @(posedge clk)
	begin
		if (reset)
			link_valid <= '0;
		else if (in.valid)
		begin
			case (in.req.op)
				OP_LOAD_SYNC:
				begin
					if (in.hit)
					begin
						link_addr[in.req.strand] <= in.req.address;
						link_valid[in.req.strand] <= 1'b1;
					end
				end

				OP_STORE, OP_STORE_SYNC:
				begin
					if (in.req.op == OP_STORE || (link_match && in.hit))
					begin
						for (int k = 0; k < `L2_NUM_STRANDS; k++)
						begin
							if (link_addr[k] == in.req.address)
								link_valid[k] <= 1'b0;
						end
					end
				end

				default:
				begin
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out.valid <= 1'b0;
			sync_success <= 1'b0;
		end
		else
		begin
			out.valid <= in.valid;
			sync_success <= in.valid && in.req.op == OP_STORE_SYNC && in.hit && link_match;
		end
		out.req <= in.req;
		out.hit <= in.hit;
		out.way <= in.way;
		out.victim_tag <= in.victim_tag;
		// Only an evicting fill or a flush hit writes the line back
		out.line_dirty <= in.line_dirty
			&& ((in.req.op == OP_FILL && !in.hit) || (in.req.op == OP_FLUSH && in.hit));
	end
endmodule

`default_nettype wire

// ==== logic/l2_cache_update.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_consts.svh"

module l2_cache_update
	import l2_cache_pkg::*;
(
	input wire clk,
	input wire reset,
	l2_stage_if.sink in,
	input wire [`L2_LINE_WIDTH-1:0] line_data,
	input wire sync_success,
	output logic wr_enable,
	output logic [`L2_INDEX_WIDTH-1:0] wr_index,
	output logic [`L2_LINE_WIDTH-1:0] wr_data,
	output logic resp_valid,
	output l2_op_t resp_op,
	output logic [$clog2(`L2_NUM_STRANDS)-1:0] resp_strand,
	output logic resp_hit,
	output logic [`L2_LINE_WIDTH-1:0] resp_data,
	output logic resp_sync_success,
	output logic resp_writeback,
	output logic [`L2_ADDR_WIDTH-1:0] resp_wb_address,
	output logic [`L2_LINE_WIDTH-1:0] resp_wb_data
);
	logic [`L2_SET_WIDTH-1:0] req_set;
	logic [`L2_LINE_WIDTH-1:0] merged;
	logic do_store;
	logic do_fill;

	assign req_set = in.req.address[`L2_SET_WIDTH-1:0];

	// Byte lane b is covered by mask bit b
	always_comb
	begin
		for (int b = 0; b < `L2_MASK_WIDTH; b++)
		begin
			merged[b * 8 +: 8] = in.req.mask[b] ? in.req.data[b * 8 +: 8]
				: line_data[b * 8 +: 8];
		end
	end

	assign do_store = in.valid && in.hit
		&& (in.req.op == OP_STORE || (in.req.op == OP_STORE_SYNC && sync_success));
	assign do_fill = in.valid && in.req.op == OP_FILL;

	assign wr_enable = do_store || do_fill;
	assign wr_index = {in.way, req_set};
	assign wr_data = do_fill ? in.req.data : merged;

	always_ff @(posedge clk)
	begin
		if (reset)
			resp_valid <= 1'b0;
		else
			resp_valid <= in.valid;
		resp_op <= in.req.op;
		resp_strand <= in.req.strand;
		resp_hit <= in.hit;
		resp_sync_success <= sync_success;
		// Line contents after this operation, zero on a plain miss
		if (wr_enable)
			resp_data <= wr_data;
		else if (in.hit)
			resp_data <= line_data;
		else
			resp_data <= '0;
		resp_writeback <= in.valid && in.line_dirty;
		resp_wb_address <= {in.victim_tag, req_set};
		resp_wb_data <= line_data;
	end
endmodule

`default_nettype wire

// ==== logic/l2_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_consts.svh"

module l2_cache
	import l2_cache_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire req_valid,
	input wire l2_op_t req_op,
	input wire [$clog2(`L2_NUM_STRANDS)-1:0] req_strand,
	input wire [`L2_ADDR_WIDTH-1:0] req_address,
	input wire [`L2_LINE_WIDTH-1:0] req_data,
	input wire [`L2_MASK_WIDTH-1:0] req_mask,
	output logic resp_valid,
	output l2_op_t resp_op,
	output logic [$clog2(`L2_NUM_STRANDS)-1:0] resp_strand,
	output logic resp_hit,
	output logic [`L2_LINE_WIDTH-1:0] resp_data,
	output logic resp_sync_success,
	output logic resp_writeback,
	output logic [`L2_ADDR_WIDTH-1:0] resp_wb_address,
	output logic [`L2_LINE_WIDTH-1:0] resp_wb_data
);
	l2_request_t req;
	logic [`L2_LINE_WIDTH-1:0] line_data;
	logic sync_success;
	logic wr_enable;
	logic [`L2_INDEX_WIDTH-1:0] wr_index;
	logic [`L2_LINE_WIDTH-1:0] wr_data;
	logic [`L2_INDEX_WIDTH-1:0] rd_index;
	logic [`L2_LINE_WIDTH-1:0] rd_data;

	assign req.op = req_op;
	assign req.strand = req_strand;
	assign req.address = req_address;
	assign req.data = req_data;
	assign req.mask = req_mask;

	l2_stage_if tag_to_read();
	l2_stage_if read_to_update();

	l2_cache_tag tag_stage(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.out(tag_to_read.source));

	l2_cache_read read_stage(
		.clk(clk),
		.reset(reset),
		.in(tag_to_read.sink),
		.out(read_to_update.source),
		.line_data(line_data),
		.sync_success(sync_success),
		.wr_enable(wr_enable),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.rd_index(rd_index),
		.rd_data(rd_data));

	l2_cache_update update_stage(
		.clk(clk),
		.reset(reset),
		.in(read_to_update.sink),
		.line_data(line_data),
		.sync_success(sync_success),
		.wr_enable(wr_enable),
		.wr_index(wr_index),
		.wr_data(wr_data),
		.resp_valid(resp_valid),
		.resp_op(resp_op),
		.resp_strand(resp_strand),
		.resp_hit(resp_hit),
		.resp_data(resp_data),
		.resp_sync_success(resp_sync_success),
		.resp_writeback(resp_writeback),
		.resp_wb_address(resp_wb_address),
		.resp_wb_data(resp_wb_data));

	l2_cache_sram #(
		.DATA_WIDTH(`L2_LINE_WIDTH),
		.ADDR_WIDTH(`L2_INDEX_WIDTH)
	) data_mem(
		.clk(clk),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.wr_enable(wr_enable),
		.wr_index(wr_index),
		.wr_data(wr_data));
endmodule

`default_nettype wire

// ==== verif/l2_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_consts.svh"

module l2_cache_tb
	import l2_cache_pkg::*;
();
	localparam int RESP_TIMEOUT = 20;
	localparam int RESP_LATENCY = 3;
	localparam int SW = $clog2(`L2_NUM_STRANDS);
	localparam int WW = `L2_INDEX_WIDTH - `L2_SET_WIDTH;

	typedef struct packed
	{
		l2_op_t op;
		logic [SW-1:0] strand;
		logic hit;
		logic [`L2_LINE_WIDTH-1:0] data;
		logic sync_success;
		logic writeback;
		logic [`L2_ADDR_WIDTH-1:0] wb_address;
		logic [`L2_LINE_WIDTH-1:0] wb_data;
	} resp_t;

	logic clk;
	logic reset;
	logic req_valid;
	l2_op_t req_op;
	logic [SW-1:0] req_strand;
	logic [`L2_ADDR_WIDTH-1:0] req_address;
	logic [`L2_LINE_WIDTH-1:0] req_data;
	logic [`L2_MASK_WIDTH-1:0] req_mask;
	logic resp_valid;
	l2_op_t resp_op;
	logic [SW-1:0] resp_strand;
	logic resp_hit;
	logic [`L2_LINE_WIDTH-1:0] resp_data;
	logic resp_sync_success;
	logic resp_writeback;
	logic [`L2_ADDR_WIDTH-1:0] resp_wb_address;
	logic [`L2_LINE_WIDTH-1:0] resp_wb_data;

	// Reference model of the directory, the lines and the sync links
	logic [`L2_TAG_WIDTH-1:0] m_tag [`L2_NUM_SETS][`L2_NUM_WAYS];
	logic m_valid [`L2_NUM_SETS][`L2_NUM_WAYS];
	logic m_dirty [`L2_NUM_SETS][`L2_NUM_WAYS];
	logic [WW-1:0] m_ptr [`L2_NUM_SETS];
	logic [`L2_LINE_WIDTH-1:0] m_data [`L2_NUM_WAYS][`L2_NUM_SETS];
	logic [`L2_ADDR_WIDTH-1:0] m_link_addr [`L2_NUM_STRANDS];
	logic m_link_valid [`L2_NUM_STRANDS];

	resp_t expected_q[$];
	resp_t received_q[$];
	int sent_cycle_q[$];
	int arrival_cycle_q[$];
	int cycle_count;
	logic [31:0] lcg_state;
	int error_count;
	int test_errors;
	int tests_run;
	int tests_failed;
	bit timed_out;

	l2_cache dut(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_strand(req_strand),
		.req_address(req_address),
		.req_data(req_data),
		.req_mask(req_mask),
		.resp_valid(resp_valid),
		.resp_op(resp_op),
		.resp_strand(resp_strand),
		.resp_hit(resp_hit),
		.resp_data(resp_data),
		.resp_sync_success(resp_sync_success),
		.resp_writeback(resp_writeback),
		.resp_wb_address(resp_wb_address),
		.resp_wb_data(resp_wb_data));

	always #4 clk = ~clk;

	// Rising edges seen so far
	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// Responses are collected between rising edges
	always @(negedge clk)
	begin
		if (resp_valid === 1'b1)
		begin
			received_q.push_back({resp_op, resp_strand, resp_hit, resp_data,
				resp_sync_success, resp_writeback, resp_wb_address, resp_wb_data});
			arrival_cycle_q.push_back(cycle_count);
		end
	end

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [`L2_LINE_WIDTH-1:0] rand_line();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = rand_word();
		lo = rand_word();
		return {hi, lo};
	endfunction

	// Partial masks only, so kept and merged bytes both show up
	function automatic logic [`L2_MASK_WIDTH-1:0] rand_mask();
		logic [31:0] r;
		r = rand_word();
		if (r[23:16] == 8'h00 || r[23:16] == 8'hff)
			return 8'h5a;
		return r[23:16];
	endfunction

	function automatic logic [`L2_LINE_WIDTH-1:0] merge_bytes(
		input logic [`L2_LINE_WIDTH-1:0] old_line,
		input logic [`L2_LINE_WIDTH-1:0] new_data,
		input logic [`L2_MASK_WIDTH-1:0] mask);
		logic [`L2_LINE_WIDTH-1:0] result;
		result = old_line;
		for (int b = 0; b < `L2_MASK_WIDTH; b++)
		begin
			if (mask[b])
				result[b * 8 +: 8] = new_data[b * 8 +: 8];
		end
		return result;
	endfunction

	task automatic reset_model();
		for (int s = 0; s < `L2_NUM_SETS; s++)
		begin
			m_ptr[s] = '0;
			for (int w = 0; w < `L2_NUM_WAYS; w++)
			begin
				m_tag[s][w] = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_data[w][s] = '0;
			end
		end
		for (int k = 0; k < `L2_NUM_STRANDS; k++)
		begin
			m_link_addr[k] = '0;
			m_link_valid[k] = 1'b0;
		end
	endtask

	task automatic clear_links(input logic [`L2_ADDR_WIDTH-1:0] addr);
		for (int k = 0; k < `L2_NUM_STRANDS; k++)
		begin
			if (m_link_addr[k] == addr)
				m_link_valid[k] = 1'b0;
		end
	endtask

	// Applies one request to the model and queues the response it predicts
	task automatic model_request(input l2_op_t op, input logic [SW-1:0] strand,
		input logic [`L2_ADDR_WIDTH-1:0] addr, input logic [`L2_LINE_WIDTH-1:0] data,
		input logic [`L2_MASK_WIDTH-1:0] mask);
		resp_t e;
		logic [`L2_SET_WIDTH-1:0] set;
		logic [`L2_TAG_WIDTH-1:0] tag;
		logic hit;
		logic free_found;
		logic [WW-1:0] way;
		logic [`L2_LINE_WIDTH-1:0] line;
		set = addr[`L2_SET_WIDTH-1:0];
		tag = addr[`L2_ADDR_WIDTH-1:`L2_SET_WIDTH];
		hit = 1'b0;
		free_found = 1'b0;
		way = m_ptr[set];
		for (int w = 0; w < `L2_NUM_WAYS; w++)
		begin
			if (!hit && m_valid[set][w] && m_tag[set][w] == tag)
			begin
				hit = 1'b1;
				way = WW'(w);
			end
		end
		// A miss takes the lowest free way or the round-robin way
		if (!hit)
		begin
			for (int w = 0; w < `L2_NUM_WAYS; w++)
			begin
				if (!free_found && !m_valid[set][w])
				begin
					free_found = 1'b1;
					way = WW'(w);
				end
			end
		end
		line = m_data[way][set];
		e = '0;
		e.op = op;
		e.strand = strand;
		e.hit = hit;
		e.data = hit ? line : '0;
		case (op)
			OP_LOAD_SYNC:
			begin
				if (hit)
				begin
					m_link_addr[strand] = addr;
					m_link_valid[strand] = 1'b1;
				end
			end
			OP_STORE:
			begin
				clear_links(addr);
				if (hit)
				begin
					m_data[way][set] = merge_bytes(line, data, mask);
					m_dirty[set][way] = 1'b1;
					e.data = m_data[way][set];
				end
			end
			OP_STORE_SYNC:
			begin
				e.sync_success = hit && m_link_valid[strand] && m_link_addr[strand] == addr;
				if (hit)
					m_dirty[set][way] = 1'b1;
				if (e.sync_success)
				begin
					clear_links(addr);
					m_data[way][set] = merge_bytes(line, data, mask);
					e.data = m_data[way][set];
				end
			end
			OP_FLUSH:
			begin
				if (hit)
				begin
					e.writeback = m_dirty[set][way];
					e.wb_address = addr;
					e.wb_data = line;
					m_dirty[set][way] = 1'b0;
				end
			end
			OP_FILL:
			begin
				if (!hit)
				begin
					e.writeback = m_valid[set][way] && m_dirty[set][way];
					e.wb_address = {m_tag[set][way], set};
					e.wb_data = line;
					m_ptr[set] = m_ptr[set] + 1'b1;
				end
				m_tag[set][way] = tag;
				m_valid[set][way] = 1'b1;
				m_dirty[set][way] = 1'b0;
				m_data[way][set] = data;
				e.data = data;
			end
			default:
			begin
			end
		endcase
		expected_q.push_back(e);
	endtask

	task automatic send(input l2_op_t op, input logic [SW-1:0] strand,
		input logic [`L2_ADDR_WIDTH-1:0] addr, input logic [`L2_LINE_WIDTH-1:0] data,
		input logic [`L2_MASK_WIDTH-1:0] mask);
		@(negedge clk);
		req_valid = 1'b1;
		req_op = op;
		req_strand = strand;
		req_address = addr;
		req_data = data;
		req_mask = mask;
		sent_cycle_q.push_back(cycle_count);
		model_request(op, strand, addr, data, mask);
	endtask

	task automatic stop_sending();
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		assert (actual === expected)
		else
		begin
			$display("ERROR at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
			test_errors++;
		end
	endtask

	// Waits for each outstanding response in order and compares it with the model
	task automatic check_responses();
		resp_t got;
		resp_t exp;
		int cycles;
		int sent_at;
		int arrived_at;
		while (expected_q.size() > 0 && !timed_out)
		begin
			cycles = 0;
			while (received_q.size() == 0 && cycles < RESP_TIMEOUT)
			begin
				@(posedge clk);
				cycles++;
			end
			if (received_q.size() == 0)
			begin
				$display("No resp_valid within %0d cycles of waiting", RESP_TIMEOUT);
				timed_out = 1'b1;
				test_errors++;
			end
			else
			begin
				got = received_q.pop_front();
				exp = expected_q.pop_front();
				arrived_at = arrival_cycle_q.pop_front();
				sent_at = sent_cycle_q.pop_front();
				check_value("resp_valid latency", 64'(arrived_at - sent_at),
					64'(RESP_LATENCY));
				check_value("resp_op", 64'(got.op), 64'(exp.op));
				check_value("resp_strand", 64'(got.strand), 64'(exp.strand));
				check_value("resp_hit", 64'(got.hit), 64'(exp.hit));
				check_value("resp_data", got.data, exp.data);
				check_value("resp_sync_success", 64'(got.sync_success),
					64'(exp.sync_success));
				check_value("resp_writeback", 64'(got.writeback), 64'(exp.writeback));
				if (exp.writeback)
				begin
					check_value("resp_wb_address", 64'(got.wb_address),
						64'(exp.wb_address));
					check_value("resp_wb_data", got.wb_data, exp.wb_data);
				end
			end
		end
	endtask

	task automatic start_test();
		test_errors = 0;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		error_count += test_errors;
		if (test_errors == 0)
			$display("%s: passed", name);
		else
		begin
			$display("%s: failed with %0d errors", name, test_errors);
			tests_failed++;
		end
	endtask

	task automatic check_after_reset();
		logic [31:0] r;
		start_test();
		repeat (5) @(negedge clk);
		assert (received_q.size() == 0)
		else
		begin
			$display("resp_valid went high after reset with no request");
			test_errors++;
		end
		for (int i = 0; i < 4; i++)
		begin
			r = rand_word();
			send(OP_LOAD, SW'(i), r[27:16], '0, '0);
		end
		stop_sending();
		check_responses();
		finish_test("reset and cold miss");
	endtask

	task automatic fill_then_load();
		start_test();
		// Back to back, so the first load reads through the bypass
		send(OP_FILL, 2'd0, 12'h231, rand_line(), '0);
		send(OP_LOAD, 2'd1, 12'h231, '0, '0);
		send(OP_LOAD, 2'd2, 12'h231, '0, '0);
		send(OP_LOAD, 2'd3, 12'h241, '0, '0);
		stop_sending();
		check_responses();
		finish_test("fill then load");
	endtask

	task automatic masked_store();
		start_test();
		send(OP_FILL, 2'd0, 12'h352, rand_line(), '0);
		send(OP_STORE, 2'd1, 12'h352, rand_line(), rand_mask());
		send(OP_LOAD, 2'd2, 12'h352, '0, '0);
		// Store miss to a line that was never filled
		send(OP_STORE, 2'd3, 12'h362, rand_line(), rand_mask());
		send(OP_LOAD, 2'd0, 12'h362, '0, '0);
		send(OP_LOAD, 2'd0, 12'h352, '0, '0);
		stop_sending();
		check_responses();
		finish_test("masked store");
	endtask

	task automatic flush_dirty_line();
		start_test();
		send(OP_FILL, 2'd0, 12'h473, rand_line(), '0);
		send(OP_STORE, 2'd1, 12'h473, rand_line(), rand_mask());
		send(OP_FLUSH, 2'd2, 12'h473, '0, '0);
		send(OP_FLUSH, 2'd2, 12'h473, '0, '0);
		send(OP_LOAD, 2'd3, 12'h473, '0, '0);
		stop_sending();
		check_responses();
		finish_test("flush");
	endtask

	task automatic evict_by_pointer();
		start_test();
		for (int t = 0; t < `L2_NUM_WAYS; t++)
			send(OP_FILL, 2'd0, {8'(16 + t), 4'h5}, rand_line(), '0);
		send(OP_STORE, 2'd1, 12'h105, rand_line(), rand_mask());
		// The full set lets the pointer pick way 0 and then way 1
		send(OP_FILL, 2'd0, 12'h145, rand_line(), '0);
		send(OP_FILL, 2'd0, 12'h155, rand_line(), '0);
		send(OP_LOAD, 2'd2, 12'h105, '0, '0);
		send(OP_LOAD, 2'd2, 12'h125, '0, '0);
		send(OP_LOAD, 2'd2, 12'h155, '0, '0);
		stop_sending();
		check_responses();
		finish_test("eviction");
	endtask

	task automatic sync_store_links();
		start_test();
		send(OP_FILL, 2'd0, 12'h5a7, rand_line(), '0);
		send(OP_LOAD_SYNC, 2'd1, 12'h5a7, '0, '0);
		send(OP_STORE_SYNC, 2'd1, 12'h5a7, rand_line(), rand_mask());
		// Another strand's plain store breaks the link of strand 2
		send(OP_LOAD_SYNC, 2'd2, 12'h5a7, '0, '0);
		send(OP_STORE, 2'd0, 12'h5a7, rand_line(), rand_mask());
		send(OP_STORE_SYNC, 2'd2, 12'h5a7, rand_line(), rand_mask());
		// Strand 3 never linked
		send(OP_STORE_SYNC, 2'd3, 12'h5a7, rand_line(), rand_mask());
		send(OP_LOAD, 2'd0, 12'h5a7, '0, '0);
		stop_sending();
		check_responses();
		finish_test("synchronized store");
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = OP_LOAD;
		req_strand = '0;
		req_address = '0;
		req_data = '0;
		req_mask = '0;
		cycle_count = 0;
		lcg_state = 32'h45e9;
		error_count = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		reset_model();
		repeat (4) @(negedge clk);
		reset = 1'b0;

		check_after_reset();
		if (!timed_out)
			fill_then_load();
		if (!timed_out)
			masked_store();
		if (!timed_out)
			flush_dirty_line();
		if (!timed_out)
			evict_by_pointer();
		if (!timed_out)
			sync_store_links();

		// Nothing should arrive once all requests are answered
		repeat (5) @(negedge clk);
		assert (received_q.size() == 0)
		else
		begin
			$display("%0d responses arrived that no request asked for", received_q.size());
			error_count++;
		end

		$display("Tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0 && !timed_out)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/l2_cache_pkg.sv
logic/l2_stage_if.sv
logic/l2_cache_sram.sv
logic/l2_cache_tag.sv
logic/l2_cache_read.sv
logic/l2_cache_update.sv
logic/l2_cache.sv
verif/l2_cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the L2 cache testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module l2_cache_tb -Mdir obj_dir -o l2_cache_sim

./obj_dir/l2_cache_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
	exit 1
fi
